// ==== flist.f ====
common/ulpi_tx_pkg.sv
hdl/usb_tx_framer.sv
ulpi_encoder/ulpi_encoder.sv
ulpi_encoder/skid_loader.sv
hdl/ulpi_tx_top.sv
test/ulpi_tx_assert.sv
test/tb_ulpi_tx.sv

// ==== Bender.yml ====
package:
  name: ulpi_tx

sources:
  - common/ulpi_tx_pkg.sv
  - hdl/usb_tx_framer.sv
  - ulpi_encoder/ulpi_encoder.sv
  - ulpi_encoder/skid_loader.sv
  - hdl/ulpi_tx_top.sv
  - target: test
    files:
      - test/ulpi_tx_assert.sv
      - test/tb_ulpi_tx.sv

// ==== test/tb_ulpi_tx.sv ====
`timescale 1ns/1ps
module tb_ulpi_tx;

  localparam int N_XFER  = 48;
  localparam int MAX_LEN = 16;

  logic       clock;
  logic       reset;
  logic       s_tvalid_i;
  logic       s_tready_o;
  logic       s_tlast_i;
  logic [7:0] s_tdata_i;
  logic [3:0] pid_i;
  logic       hsk_i;
  logic       reg_valid_i;
  logic       reg_ready_o;
  logic [5:0] reg_addr_i;
  logic [7:0] reg_data_i;
  logic       ulpi_dir_i;
  logic       ulpi_nxt_i;
  logic       ulpi_stp_o;
  logic [7:0] ulpi_data_o;
  logic       tx_busy_o;
  logic       tx_done_o;

  logic [31:0] lfsr_q;
  // Transfer kinds are 0 packet, 1 handshake, 2 register write
  int          kind_a [N_XFER];
  logic [3:0]  pid_a [N_XFER];
  int          len_a [N_XFER];
  logic [5:0]  addr_a [N_XFER];
  logic [7:0]  rdat_a [N_XFER];
  int          gap_a [N_XFER];
  logic [7:0]  data_a [N_XFER*MAX_LEN];
  logic [7:0]  exp_pkt[$];
  int          exp_len[$];
  logic [15:0] exp_reg[$];
  logic [7:0]  got[$];
  int          timeout_cycles;
  int          xfers_seen;
  int          done_count;
  logic        in_xfer;
  logic        hold_dir;
  logic        dir_prev;
  int          dir_cnt;

  ulpi_tx_top u_dut (.*);

  bind skid_loader ulpi_tx_assert u_assert (
    .clock        (clock),
    .reset        (reset),
    .byte_valid_i (m_valid_q),
    .nxt_i        (ulpi_nxt_i),
    .stp_i        (ulpi_stp_o),
    .data_i       (ulpi_data_o)
  );

  always #2 clock = ~clock;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Bit serial USB CRC16, data LSB first
  function automatic logic [15:0] crc16_model(input logic [15:0] crc, input logic [7:0] b);
    logic [15:0] c;
    logic        fb;
    c = crc;
    for (int k = 0; k < 8; k++) begin
      fb = c[0] ^ b[k];
      c = {1'b0, c[15:1]};
      if (fb) begin
        c = c ^ 16'hA001;
      end
    end
    return c;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      stop_on_error($sformatf("FAILED %s: expected %0h, actual %0h", name, exp, act));
    end
  endtask

  // Holds one beat on the stream until the DUT takes it
  task automatic send_beat(input logic [7:0] d, input logic last);
    s_tvalid_i = 1'b1;
    s_tdata_i  = d;
    s_tlast_i  = last;
    #1;
    while (!s_tready_o) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
  endtask

  task automatic send_reg(input logic [5:0] addr, input logic [7:0] data);
    reg_valid_i = 1'b1;
    reg_addr_i  = addr;
    reg_data_i  = data;
    #1;
    while (!reg_ready_o) begin
      @(negedge clock);
      #1;
    end
    @(negedge clock);
    reg_valid_i = 1'b0;
  endtask

  task automatic compare_transfer;
    logic [15:0] rw;
    int          n;
    if (got.size() == 0) begin
      stop_on_error("Stop cycle ended a transfer that carried no bytes");
    end
    if (got[0][7:6] == 2'b10) begin
      if (exp_reg.size() == 0) begin
        stop_on_error("Register write seen on the bus with none requested");
      end
      rw = exp_reg.pop_front();
      check_value("regw_length", 32'd2, 32'(got.size()));
      check_value("regw_cmd", 32'(rw[15:8]), 32'(got[0]));
      check_value("regw_data", 32'(rw[7:0]), 32'(got[1]));
    end else begin
      if (exp_len.size() == 0) begin
        stop_on_error("Packet seen on the bus with none requested");
      end
      n = exp_len.pop_front();
      check_value("pkt_length", 32'(n), 32'(got.size()));
      for (int k = 0; k < n; k++) begin
        check_value("pkt_byte", 32'(exp_pkt.pop_front()), 32'(got[k]));
      end
    end
    // The first two requests are pending together, the write goes first
    if (xfers_seen == 0) begin
      check_value("priority_regw_first", 32'd2, 32'(got[0][7:6]));
    end
    xfers_seen++;
    got.delete();
  endtask

  // PHY model and bus monitor
  always @(negedge clock) begin : phy_model
    logic [31:0] r;
    logic        nxt_now;
    r = rand_bits(7);
    nxt_now = r[1:0] != 2'b00;
    if (!reset) begin
      if (ulpi_dir_i || dir_prev) begin
        check_value("dir_busy", 32'd0, 32'(tx_busy_o));
        check_value("dir_stp", 32'd0, 32'(ulpi_stp_o));
        check_value("dir_data", 32'd0, 32'(ulpi_data_o));
      end
      if (tx_done_o) begin
        done_count++;
      end
      if (ulpi_stp_o) begin
        if (!in_xfer) begin
          stop_on_error("Stop cycle seen outside of a transfer");
        end
        check_value("stop_data", 32'd0, 32'(ulpi_data_o));
        compare_transfer();
        in_xfer = 1'b0;
      end else if (nxt_now && (in_xfer || ulpi_data_o != 8'h00)) begin
        got.push_back(ulpi_data_o);
        in_xfer = 1'b1;
      end
    end
    ulpi_nxt_i = nxt_now;
    dir_prev = ulpi_dir_i;
    // Turnaround only while the link is quiet
    if (hold_dir) begin
      ulpi_dir_i = 1'b1;
    end else if (ulpi_dir_i) begin
      if (dir_cnt == 0) begin
        ulpi_dir_i = 1'b0;
      end else begin
        dir_cnt--;
      end
    end else if (!tx_busy_o && !in_xfer && !ulpi_stp_o && ulpi_data_o == 8'h00 &&
                 r[4:2] == 3'b000) begin
      ulpi_dir_i = 1'b1;
      dir_cnt = int'(r[6:5]);
    end
  end

  initial begin
    #1;
    repeat (timeout_cycles) @(posedge clock);
    stop_on_error("Timeout while waiting for all transfers to finish");
  end

  initial begin
    logic [31:0] r;
    logic [15:0] crc;
    logic [7:0]  cmd;
    int          nbytes;
    clock       = 1'b0;
    reset       = 1'b1;
    s_tvalid_i  = 1'b0;
    s_tlast_i   = 1'b0;
    s_tdata_i   = 8'h00;
    pid_i       = 4'h0;
    hsk_i       = 1'b0;
    reg_valid_i = 1'b0;
    reg_addr_i  = 6'h00;
    reg_data_i  = 8'h00;
    ulpi_dir_i  = 1'b1;
    ulpi_nxt_i  = 1'b0;
    hold_dir    = 1'b1;
    dir_prev    = 1'b1;
    dir_cnt     = 0;
    in_xfer     = 1'b0;
    xfers_seen  = 0;
    done_count  = 0;
    nbytes      = 0;
    lfsr_q      = 32'heef1e18e;
    for (int i = 0; i < N_XFER; i++) begin
      r = rand_bits(3);
      kind_a[i] = (r[2:0] < 3'd4) ? 0 : (r[2:0] < 3'd6) ? 1 : 2;
      if (i == 0) begin
        kind_a[i] = 0;
      end
      if (i == 1) begin
        kind_a[i] = 2;
      end
      r = rand_bits(4);
      pid_a[i] = r[3:0];
      r = rand_bits(4);
      len_a[i] = int'(r[3:0]) + 1;
      r = rand_bits(6);
      addr_a[i] = r[5:0];
      r = rand_bits(8);
      rdat_a[i] = r[7:0];
      r = rand_bits(2);
      gap_a[i] = (i < 2) ? 0 : int'(r[1:0]);
      crc = 16'hFFFF;
      for (int j = 0; j < len_a[i]; j++) begin
        r = rand_bits(8);
        data_a[i*MAX_LEN+j] = r[7:0];
        crc = crc16_model(crc, r[7:0]);
      end
      cmd = {2'b01, 2'b00, pid_a[i]};
      if (kind_a[i] == 2) begin
        exp_reg.push_back({2'b10, addr_a[i], rdat_a[i]});
        nbytes += 3;
      end else if (kind_a[i] == 1) begin
        exp_pkt.push_back(cmd);
        exp_len.push_back(1);
        nbytes += 2;
      end else begin
        exp_pkt.push_back(cmd);
        for (int j = 0; j < len_a[i]; j++) begin
          exp_pkt.push_back(data_a[i*MAX_LEN+j]);
        end
        exp_pkt.push_back(~crc[7:0]);
        exp_pkt.push_back(~crc[15:8]);
        exp_len.push_back(len_a[i] + 3);
        nbytes += len_a[i] + 4;
      end
    end
    timeout_cycles = 40 * nbytes + 400;

    repeat (4) @(negedge clock);
    check_value("reset_stp", 32'd0, 32'(ulpi_stp_o));
    check_value("reset_busy", 32'd0, 32'(tx_busy_o));
    check_value("reset_done", 32'd0, 32'(tx_done_o));
    check_value("reset_data", 32'd0, 32'(ulpi_data_o));
    check_value("reset_s_tready", 32'd0, 32'(s_tready_o));
    check_value("reset_reg_ready", 32'd0, 32'(reg_ready_o));
    reset = 1'b0;

    fork
      begin
        for (int i = 0; i < N_XFER; i++) begin
          if (kind_a[i] != 2) begin
            repeat (gap_a[i]) @(negedge clock);
            pid_i = pid_a[i];
            hsk_i = kind_a[i] == 1;
            if (kind_a[i] == 1) begin
              send_beat(data_a[i*MAX_LEN], 1'b1);
            end else begin
              for (int j = 0; j < len_a[i]; j++) begin
                send_beat(data_a[i*MAX_LEN+j], j == len_a[i] - 1);
              end
            end
            s_tvalid_i = 1'b0;
            s_tlast_i  = 1'b0;
            hsk_i      = 1'b0;
          end
        end
      end
      begin
        for (int i = 0; i < N_XFER; i++) begin
          if (kind_a[i] == 2) begin
            repeat (gap_a[i]) @(negedge clock);
            send_reg(addr_a[i], rdat_a[i]);
          end
        end
      end
      begin
        // PHY owns the bus while the first packet and write queue up
        repeat (8) @(negedge clock);
        @(posedge clock);
        hold_dir = 1'b0;
      end
    join

    while (xfers_seen < N_XFER) @(negedge clock);
    repeat (6) @(negedge clock);
    check_value("done_pulses", 32'(N_XFER), 32'(done_count));
    check_value("busy_at_end", 32'd0, 32'(tx_busy_o));
    check_value("pkt_bytes_left", 32'd0, 32'(exp_pkt.size()));
    check_value("regw_left", 32'd0, 32'(exp_reg.size()));
    $display("No errors");
    $finish;
  end

endmodule

// ==== test/ulpi_tx_assert.sv ====
`timescale 1ns/1ps
module ulpi_tx_assert (
  input logic       clock,
  input logic       reset,
  input logic       byte_valid_i,
  input logic       nxt_i,
  input logic       stp_i,
  input logic [7:0] data_i
);

  // Stop is a single cycle pulse
  stp_one_cycle: assert property (@(posedge clock) disable iff (reset)
    stp_i |=> !stp_i)
    else $error("ulpi_stp_o stayed high for more than one cycle");

  stp_data_zero: assert property (@(posedge clock) disable iff (reset)
    stp_i |-> data_i == 8'h00)
    else $error("ulpi_data_o not zero during the stop cycle");

  // A presented byte waits for nxt
  byte_held: assert property (@(posedge clock) disable iff (reset)
    (byte_valid_i && !stp_i && !nxt_i) |=> (byte_valid_i && !stp_i && $stable(data_i)))
    else $error("ulpi_data_o changed while nxt was low");

endmodule

// ==== hdl/ulpi_tx_top.sv ====
`timescale 1ns/1ps
module ulpi_tx_top (
  input  logic       clock,
  input  logic       reset,
  input  logic       s_tvalid_i,
  output logic       s_tready_o,
  input  logic       s_tlast_i,
  input  logic [7:0] s_tdata_i,
  input  logic [3:0] pid_i,
  input  logic       hsk_i,
  input  logic       reg_valid_i,
  output logic       reg_ready_o,
  input  logic [5:0] reg_addr_i,
  input  logic [7:0] reg_data_i,
  input  logic       ulpi_dir_i,
  input  logic       ulpi_nxt_i,
  output logic       ulpi_stp_o,
  output logic [7:0] ulpi_data_o,
  output logic       tx_busy_o,
  output logic       tx_done_o
);

  logic                    fr_valid;
  logic                    fr_ready;
  ulpi_tx_pkg::usb_beat_t  fr_beat;
  logic                    en_valid;
  logic                    en_ready;
  ulpi_tx_pkg::ulpi_beat_t en_beat;

  usb_tx_framer u_framer (
    .clock      (clock),
    .reset      (reset),
    .s_tvalid_i (s_tvalid_i),
    .s_tready_o (s_tready_o),
    .s_tlast_i  (s_tlast_i),
    .s_tdata_i  (s_tdata_i),
    .pid_i      (pid_i),
    .hsk_i      (hsk_i),
    .fr_valid_o (fr_valid),
    .fr_ready_i (fr_ready),
    .fr_beat_o  (fr_beat)
  );

  ulpi_encoder u_encoder (
    .clock       (clock),
    .reset       (reset),
    .ulpi_dir_i  (ulpi_dir_i),
    .fr_valid_i  (fr_valid),
    .fr_ready_o  (fr_ready),
    .fr_beat_i   (fr_beat),
    .reg_valid_i (reg_valid_i),
    .reg_ready_o (reg_ready_o),
    .reg_addr_i  (reg_addr_i),
    .reg_data_i  (reg_data_i),
    .en_valid_o  (en_valid),
    .en_ready_i  (en_ready),
    .en_beat_o   (en_beat),
    .tx_busy_o   (tx_busy_o),
    .tx_done_o   (tx_done_o)
  );

  skid_loader u_skid (
    .clock       (clock),
    .reset       (reset),
    .s_valid_i   (en_valid),
    .s_ready_o   (en_ready),
    .s_beat_i    (en_beat),
    .ulpi_nxt_i  (ulpi_nxt_i),
    .ulpi_stp_o  (ulpi_stp_o),
    .ulpi_data_o (ulpi_data_o)
  );

endmodule

// ==== ulpi_encoder/skid_loader.sv ====
`timescale 1ns/1ps
module skid_loader (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    s_valid_i,
  output logic                    s_ready_o,
  input  ulpi_tx_pkg::ulpi_beat_t s_beat_i,
  input  logic                    ulpi_nxt_i,
  output logic                    ulpi_stp_o,
  output logic [7:0]              ulpi_data_o
);

  logic                    m_valid_q;
  logic                    o_valid_q;
  logic                    s_fire;
  logic                    m_pop;
  logic                    m_free;
  ulpi_tx_pkg::ulpi_beat_t m_beat_q;
  ulpi_tx_pkg::ulpi_beat_t o_beat_q;

  // Room as long as the overflow slot is empty
  assign s_ready_o = !o_valid_q;
  assign s_fire    = s_valid_i && s_ready_o;

  // A byte leaves on nxt, a stop beat after its one cycle
  assign m_pop  = m_valid_q && (m_beat_q.stop || ulpi_nxt_i);
  assign m_free = !m_valid_q || m_pop;

  assign ulpi_stp_o  = m_valid_q && m_beat_q.stop;
  assign ulpi_data_o = (m_valid_q && !m_beat_q.stop) ? m_beat_q.data : 8'h00;

  always_ff @(posedge clock) begin
    if (reset) begin
      m_valid_q <= 1'b0;
      o_valid_q <= 1'b0;
    end else if (m_free) begin
      // Overflow drains first so order is kept
      m_valid_q <= o_valid_q || s_fire;
      o_valid_q <= 1'b0;
    end else if (s_fire) begin
      o_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (m_free) begin
      if (o_valid_q) begin
        m_beat_q <= o_beat_q;
      end else if (s_fire) begin
        m_beat_q <= s_beat_i;
      end
    end else if (s_fire) begin
      o_beat_q <= s_beat_i;
    end
  end

endmodule

// ==== ulpi_encoder/ulpi_encoder.sv ====
`timescale 1ns/1ps
module ulpi_encoder (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    ulpi_dir_i,
  input  logic                    fr_valid_i,
  output logic                    fr_ready_o,
  input  ulpi_tx_pkg::usb_beat_t  fr_beat_i,
  input  logic                    reg_valid_i,
  output logic                    reg_ready_o,
  input  logic [5:0]              reg_addr_i,
  input  logic [7:0]              reg_data_i,
  output logic                    en_valid_o,
  input  logic                    en_ready_i,
  output ulpi_tx_pkg::ulpi_beat_t en_beat_o,
  output logic                    tx_busy_o,
  output logic                    tx_done_o
);

  logic [5:0]              state_q;
  logic [5:0]              state_d;
  logic                    dir_q;
  logic                    done_q;
  logic                    out_free;
  logic                    start_ok;
  logic                    load;
  logic [5:0]              reg_addr_q;
  logic [7:0]              reg_data_q;
  ulpi_tx_pkg::ulpi_cmd_t  cmd_tx;
  ulpi_tx_pkg::ulpi_cmd_t  cmd_regw;
  ulpi_tx_pkg::ulpi_beat_t beat_d;

  assign out_free = !en_valid_o || en_ready_i;
  // Bus must have been ours for this cycle and the one before
  assign start_ok = !ulpi_dir_i && !dir_q && out_free;

  assign tx_busy_o = state_q != ulpi_tx_pkg::EN_IDLE;
  assign tx_done_o = done_q;

  always_comb begin
    cmd_tx           = '0;
    cmd_tx.tx.code   = ulpi_tx_pkg::ULPI_CMD_TX;
    cmd_tx.tx.zero   = 2'b00;
    cmd_tx.tx.pid    = fr_beat_i.data[3:0];
    cmd_regw         = '0;
    cmd_regw.regw.code = ulpi_tx_pkg::ULPI_CMD_REGW;
    cmd_regw.regw.addr = reg_addr_q;
  end

  always_comb begin
    state_d     = state_q;
    load        = 1'b0;
    fr_ready_o  = 1'b0;
    reg_ready_o = 1'b0;
    beat_d.data = fr_beat_i.data;
    beat_d.stop = 1'b0;
    case (state_q)
      ulpi_tx_pkg::EN_IDLE: begin
        // Register writes take priority over packets
        reg_ready_o = start_ok;
        fr_ready_o  = start_ok && !reg_valid_i;
        if (start_ok && reg_valid_i) begin
          state_d = ulpi_tx_pkg::EN_RCMD;
        end else if (start_ok && fr_valid_i && fr_beat_i.kind == ulpi_tx_pkg::KIND_PID) begin
          load        = 1'b1;
          beat_d.data = cmd_tx;
          state_d     = fr_beat_i.last ? ulpi_tx_pkg::EN_STOP : ulpi_tx_pkg::EN_PKT;
        end
        // a stray non-PID beat at idle is simply dropped
      end
      ulpi_tx_pkg::EN_PKT: begin
        fr_ready_o = out_free;
        if (fr_valid_i && out_free) begin
          load = 1'b1;
          if (fr_beat_i.last) begin
            state_d = ulpi_tx_pkg::EN_STOP;
          end
        end
      end
      ulpi_tx_pkg::EN_RCMD: begin
        beat_d.data = cmd_regw;
        if (out_free) begin
          load    = 1'b1;
          state_d = ulpi_tx_pkg::EN_RDAT;
        end
      end
      ulpi_tx_pkg::EN_RDAT: begin
        beat_d.data = reg_data_q;
        if (out_free) begin
          load    = 1'b1;
          state_d = ulpi_tx_pkg::EN_STOP;
        end
      end
      ulpi_tx_pkg::EN_STOP: begin
        beat_d.data = 8'h00;
        beat_d.stop = 1'b1;
        if (out_free) begin
          load    = 1'b1;
          state_d = ulpi_tx_pkg::EN_DONE;
        end
      end
      ulpi_tx_pkg::EN_DONE: begin
        // Only the stop beat can be in the output register here
        if (en_valid_o && en_ready_i) begin
          state_d = ulpi_tx_pkg::EN_IDLE;
        end
      end
      default: begin
        state_d = ulpi_tx_pkg::EN_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= ulpi_tx_pkg::EN_IDLE;
      // Treat the bus as PHY owned until dir has been seen low
      dir_q      <= 1'b1;
      done_q     <= 1'b0;
      en_valid_o <= 1'b0;
    end else begin
      state_q <= state_d;
      dir_q   <= ulpi_dir_i;
      done_q  <= state_q == ulpi_tx_pkg::EN_DONE && en_valid_o && en_ready_i;
      if (load) begin
        en_valid_o <= 1'b1;
      end else if (en_ready_i) begin
        en_valid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      en_beat_o <= beat_d;
    end
    if (reg_valid_i && reg_ready_o) begin
      reg_addr_q <= reg_addr_i;
      reg_data_q <= reg_data_i;
    end
  end

endmodule

// ==== hdl/usb_tx_framer.sv ====
`timescale 1ns/1ps
module usb_tx_framer (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   s_tvalid_i,
  output logic                   s_tready_o,
  input  logic                   s_tlast_i,
  input  logic [7:0]             s_tdata_i,
  input  logic [3:0]             pid_i,
  input  logic                   hsk_i,
  output logic                   fr_valid_o,
  input  logic                   fr_ready_i,
  output ulpi_tx_pkg::usb_beat_t fr_beat_o
);

  logic [1:0]             state_q;
  logic [1:0]             state_d;
  logic [15:0]            crc_q;
  logic                   live_q;
  logic                   out_free;
  logic                   load;
  logic                   s_fire;
  ulpi_tx_pkg::usb_beat_t beat_d;

  // Output register can take a beat when empty or draining this cycle
  assign out_free = !fr_valid_o || fr_ready_i;
  assign s_fire   = s_tvalid_i && s_tready_o;

  always_comb begin
    state_d     = state_q;
    load        = 1'b0;
    s_tready_o  = 1'b0;
    beat_d.data = s_tdata_i;
    beat_d.last = 1'b0;
    beat_d.kind = ulpi_tx_pkg::KIND_DATA;
    case (state_q)
      ulpi_tx_pkg::FR_PID: begin
        // The first byte stays on the input until the PID beat has gone out,
        // a handshake beat carries no data and is consumed at once
        s_tready_o  = live_q && out_free && hsk_i;
        beat_d.data = {~pid_i, pid_i};
        beat_d.last = hsk_i;
        beat_d.kind = ulpi_tx_pkg::KIND_PID;
        if (live_q && out_free && s_tvalid_i) begin
          load = 1'b1;
          if (!hsk_i) begin
            state_d = ulpi_tx_pkg::FR_DATA;
          end
        end
      end
      ulpi_tx_pkg::FR_DATA: begin
        s_tready_o = out_free;
        if (s_tvalid_i && out_free) begin
          load = 1'b1;
          if (s_tlast_i) begin
            state_d = ulpi_tx_pkg::FR_CRC0;
          end
        end
      end
      ulpi_tx_pkg::FR_CRC0: begin
        beat_d.data = ~crc_q[7:0];
        beat_d.kind = ulpi_tx_pkg::KIND_CRC;
        if (out_free) begin
          load    = 1'b1;
          state_d = ulpi_tx_pkg::FR_CRC1;
        end
      end
      default: begin
        beat_d.data = ~crc_q[15:8];
        beat_d.last = 1'b1;
        beat_d.kind = ulpi_tx_pkg::KIND_CRC;
        if (out_free) begin
          load    = 1'b1;
          state_d = ulpi_tx_pkg::FR_PID;
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      live_q     <= 1'b0;
      state_q    <= ulpi_tx_pkg::FR_PID;
      fr_valid_o <= 1'b0;
      crc_q      <= ulpi_tx_pkg::CRC16_INIT;
    end else begin
      live_q  <= 1'b1;
      state_q <= state_d;
      if (load) begin
        fr_valid_o <= 1'b1;
      end else if (fr_ready_i) begin
        fr_valid_o <= 1'b0;
      end
      // Only data bytes enter the CRC, and it restarts once the high byte is out
      if (state_q == ulpi_tx_pkg::FR_DATA && s_fire) begin
        crc_q <= ulpi_tx_pkg::crc16_next(crc_q, s_tdata_i);
      end else if (state_q == ulpi_tx_pkg::FR_CRC1 && load) begin
        crc_q <= ulpi_tx_pkg::CRC16_INIT;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      fr_beat_o <= beat_d;
    end
  end

endmodule

// ==== common/ulpi_tx_pkg.sv ====
package ulpi_tx_pkg;

  // ULPI command codes, upper two bits of the command byte
  localparam logic [1:0] ULPI_CMD_TX   = 2'b01;
  localparam logic [1:0] ULPI_CMD_REGW = 2'b10;

  // USB CRC16, reflected form of x^16 + x^15 + x^2 + 1
  localparam logic [15:0] CRC16_POLY = 16'hA001;
  localparam logic [15:0] CRC16_INIT = 16'hFFFF;

  // Beat kinds on the framer to encoder link
  localparam logic [1:0] KIND_PID  = 2'd0;
  localparam logic [1:0] KIND_DATA = 2'd1;
  localparam logic [1:0] KIND_CRC  = 2'd2;

  // Framer states
  localparam logic [1:0] FR_PID  = 2'd0;
  localparam logic [1:0] FR_DATA = 2'd1;
  localparam logic [1:0] FR_CRC0 = 2'd2;
  localparam logic [1:0] FR_CRC1 = 2'd3;

  // Encoder states, one-hot
  localparam logic [5:0] EN_IDLE = 6'b000001;
  localparam logic [5:0] EN_PKT  = 6'b000010;
  localparam logic [5:0] EN_RCMD = 6'b000100;
  localparam logic [5:0] EN_RDAT = 6'b001000;
  localparam logic [5:0] EN_STOP = 6'b010000;
  localparam logic [5:0] EN_DONE = 6'b100000;

  typedef struct packed {
    logic [1:0] code;
    logic [1:0] zero;
    logic [3:0] pid;
  } ulpi_tx_cmd_t;

  typedef struct packed {
    logic [1:0] code;
    logic [5:0] addr;
  } ulpi_regw_cmd_t;

  // One command byte, read as either a transmit or a register write
  typedef union packed {
    ulpi_tx_cmd_t   tx;
    ulpi_regw_cmd_t regw;
  } ulpi_cmd_t;

  typedef struct packed {
    logic [7:0] data;
    logic       last;
    logic [1:0] kind;
  } usb_beat_t;

  typedef struct packed {
    logic [7:0] data;
    logic       stop;
  } ulpi_beat_t;

  // Fold one byte into the running CRC16, LSB first
  function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc ^ {8'h00, data};
    for (int i = 0; i < 8; i++) begin
      if (c[0]) begin
        c = (c >> 1) ^ CRC16_POLY;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage
